//--- Makefile
VERILATOR ?= verilator
TOP       ?= dmg_timing_tb
FILELIST  ?= dmg_timing_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) common/dmg_timing_consts.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- clocks_reset/clocks_reset.sv
`timescale 1ns/100ps

`include "dmg_timing_consts.svh"

module clocks_reset import dmg_timing_pkg::*; (
	input  logic                      clkin_a,
	input  logic                      rst_n,
	input  bus_req_t                  bus_req,
	input  logic                      lcd_on,
	input  timer_regs_t               timer_regs,
	output reg_wr_t                   reg_wr,
	output logic [`DMG_DIV_WIDTH-1:0] div_taps,
	output rst_out_t                  rst_out,
	output logic                      phi,
	output logic                      mcycle,
	output logic [7:0]                rdata
);

	reg_sel_e reg_sel;
	logic     div_clear;

	phase_seq phase_seq_inst (
		.clkin_a     (clkin_a),
		.rst_n       (rst_n),
		.release_tap (div_taps[`DMG_RST_RELEASE_BIT]),
		.lcd_on      (lcd_on),
		.phase       (),
		.mcycle      (mcycle),
		.phi         (phi),
		.rst_out     (rst_out)
	);

	div_counter div_counter_inst (
		.clkin_a (clkin_a),
		.rst_n   (rst_n),
		.clear   (div_clear),
		.count   (div_taps)
	);

	always_comb begin
		case (bus_req.addr)
			`DMG_ADDR_DIV: reg_sel = REG_DIV;
			`DMG_ADDR_TIMA: reg_sel = REG_TIMA;
			`DMG_ADDR_TMA: reg_sel = REG_TMA;
			`DMG_ADDR_TAC: reg_sel = REG_TAC;
			default: reg_sel = REG_NONE;
		endcase
	end

	assign reg_wr.sel = reg_sel;
	assign reg_wr.data = bus_req.wdata;
	assign reg_wr.stb = bus_req.wr && mcycle && (reg_sel != REG_NONE);
	assign div_clear = reg_wr.stb && (reg_sel == REG_DIV);

	always_comb begin
		rdata = 8'h00;
		if (bus_req.rd) begin
			case (reg_sel)
				REG_DIV: rdata = div_taps[`DMG_DIV_WIDTH-1 -: 8];
				REG_TIMA: rdata = timer_regs.tima;
				REG_TMA: rdata = timer_regs.tma;
				REG_TAC: rdata = {5'b11111, timer_regs.tac}; // unused bits read as one.
				default: rdata = 8'h00;
			endcase
		end
	end

endmodule

//--- clocks_reset/div_counter.sv
`timescale 1ns/100ps

`include "dmg_timing_consts.svh"

module div_counter (
	input  logic                      clkin_a,
	input  logic                      rst_n,
	input  logic                      clear,
	output logic [`DMG_DIV_WIDTH-1:0] count
);

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0; // a write to the upper byte clears all of it.
		end else begin
			count <= count + 1'b1;
		end
	end

	a_clear_zero: assert property (@(posedge clkin_a) disable iff (!rst_n)
		clear |=> count == '0)
		else $error("divider not zero after clear");

endmodule

//--- clocks_reset/phase_seq.sv
`timescale 1ns/100ps

module phase_seq import dmg_timing_pkg::*; (
	input  logic     clkin_a,
	input  logic     rst_n,
	input  logic     release_tap,
	input  logic     lcd_on,
	output phase_e   phase,
	output logic     mcycle,
	output logic     phi,
	output rst_out_t rst_out
);

	phase_e     phase_next;
	rst_state_e rst_state;
	rst_state_e rst_next;
	logic       sys_nreset_q;
	logic       video_nreset_q;

	always_comb begin
		case (phase)
			PH_A: phase_next = PH_B;
			PH_B: phase_next = PH_C;
			PH_C: phase_next = PH_D;
			default: phase_next = PH_A;
		endcase
	end

	always_comb begin
		rst_next = rst_state;
		case (rst_state)
			RST_HOLD: rst_next = RST_WAIT;
			RST_WAIT: begin
				if (release_tap) begin
					rst_next = RST_RUN; // divider has counted far enough.
				end
			end
			RST_RUN: rst_next = RST_RUN;
			default: rst_next = RST_HOLD;
		endcase
	end

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_A;
			rst_state <= RST_HOLD;
			sys_nreset_q <= 1'b0;
			video_nreset_q <= 1'b0;
		end else begin
			phase <= phase_next;
			rst_state <= rst_next;
			sys_nreset_q <= (rst_next == RST_RUN); // a flop so the reset never glitches.
			video_nreset_q <= sys_nreset_q & lcd_on;
		end
	end

	assign mcycle = (phase == PH_D);
	assign phi = (phase == PH_C) || (phase == PH_D);
	assign rst_out.sys_nreset = sys_nreset_q;
	assign rst_out.video_nreset = video_nreset_q;

	a_phase_step: assert property (@(posedge clkin_a) disable iff (!rst_n)
		1'b1 |=> phase == phase_e'($past(phase) + 2'd1))
		else $error("phase did not advance by one step");

	a_sys_rst_hold: assert property (@(posedge clkin_a) disable iff (!rst_n)
		rst_out.sys_nreset |=> rst_out.sys_nreset)
		else $error("sys_nreset fell while rst_n was high");

endmodule

//--- common/dmg_timing_consts.svh
`ifndef DMG_TIMING_CONSTS_SVH
`define DMG_TIMING_CONSTS_SVH

`define DMG_ADDR_DIV  16'hFF04
`define DMG_ADDR_TIMA 16'hFF05
`define DMG_ADDR_TMA  16'hFF06
`define DMG_ADDR_TAC  16'hFF07

`define DMG_DIV_WIDTH 16

// timer taps in the order of the two low control bits.
`define DMG_TAP_4096   9
`define DMG_TAP_262144 3
`define DMG_TAP_65536  5
`define DMG_TAP_16384  7

`define DMG_TAP_FRAME 12

`define DMG_RST_RELEASE_BIT 10

`endif

//--- common/dmg_timing_pkg.sv
package dmg_timing_pkg;

	// four crystal cycles make one machine cycle.
	typedef enum logic [1:0] {
		PH_A,
		PH_B,
		PH_C,
		PH_D
	} phase_e;

	typedef enum logic [1:0] {
		RST_HOLD,
		RST_WAIT,
		RST_RUN
	} rst_state_e;

	typedef enum logic [2:0] {
		REG_NONE,
		REG_DIV,
		REG_TIMA,
		REG_TMA,
		REG_TAC
	} reg_sel_e;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
		logic        rd;
	} bus_req_t;

	typedef struct packed {
		reg_sel_e   sel;
		logic [7:0] data;
		logic       stb; // only high in the machine strobe cycle.
	} reg_wr_t;

	typedef struct packed {
		logic [7:0] tima;
		logic [7:0] tma;
		logic [2:0] tac;
	} timer_regs_t;

	typedef struct packed {
		logic sys_nreset;
		logic video_nreset;
	} rst_out_t;

	typedef struct packed {
		logic       length_clk;
		logic       env_clk;
		logic       sweep_clk;
		logic [2:0] step;
	} frame_clk_t;

endpackage

//--- dmg_timing_top.f
+incdir+common
common/dmg_timing_pkg.sv
clocks_reset/phase_seq.sv
clocks_reset/div_counter.sv
clocks_reset/clocks_reset.sv
src/timer_unit.sv
src/apu_frame_seq.sv
src/dmg_timing_top.sv
verif/dmg_timing_tb.sv

//--- src/apu_frame_seq.sv
`timescale 1ns/100ps

`include "dmg_timing_consts.svh"

module apu_frame_seq import dmg_timing_pkg::*; (
	input  logic                      clkin_a,
	input  logic                      sys_nreset,
	input  logic                      apu_on,
	input  logic [`DMG_DIV_WIDTH-1:0] div_taps,
	output frame_clk_t                frame_clk
);

	logic       frame_bit_q;
	logic       frame_fall;
	logic       tick_q;
	logic       tick;
	logic [2:0] step_q;

	assign frame_fall = frame_bit_q & ~div_taps[`DMG_TAP_FRAME];

	always_ff @(posedge clkin_a or negedge sys_nreset) begin
		if (!sys_nreset) begin
			frame_bit_q <= 1'b0;
			tick_q <= 1'b0;
			step_q <= 3'd0;
		end else begin
			frame_bit_q <= div_taps[`DMG_TAP_FRAME]; // tracked even while the apu is off.
			if (!apu_on) begin
				tick_q <= 1'b0;
				step_q <= 3'd0;
			end else begin
				tick_q <= frame_fall;
				if (frame_fall) begin
					step_q <= step_q + 3'd1;
				end
			end
		end
	end

	// strobes belong to the step that was just entered.
	assign tick = tick_q & apu_on;
	assign frame_clk.length_clk = tick & ~step_q[0];
	assign frame_clk.sweep_clk = tick & (step_q[1:0] == 2'b10);
	assign frame_clk.env_clk = tick & (step_q == 3'd7);
	assign frame_clk.step = apu_on ? step_q : 3'd0;

endmodule

//--- src/dmg_timing_top.sv
`timescale 1ns/100ps

`include "dmg_timing_consts.svh"

module dmg_timing_top import dmg_timing_pkg::*; (
	input  logic       clkin_a,
	input  logic       rst_n,
	input  bus_req_t   bus_req,
	input  logic       lcd_on,
	input  logic       apu_on,
	output logic [7:0] rdata,
	output rst_out_t   rst_out,
	output logic       phi,
	output logic       mcycle,
	output logic       timer_irq,
	output frame_clk_t frame_clk
);

	reg_wr_t                   reg_wr;
	logic [`DMG_DIV_WIDTH-1:0] div_taps;
	timer_regs_t               timer_regs;

	clocks_reset clocks_reset_inst (
		.clkin_a    (clkin_a),
		.rst_n      (rst_n),
		.bus_req    (bus_req),
		.lcd_on     (lcd_on),
		.timer_regs (timer_regs),
		.reg_wr     (reg_wr),
		.div_taps   (div_taps),
		.rst_out    (rst_out),
		.phi        (phi),
		.mcycle     (mcycle),
		.rdata      (rdata)
	);

	timer_unit timer_unit_inst (
		.clkin_a    (clkin_a),
		.sys_nreset (rst_out.sys_nreset),
		.reg_wr     (reg_wr),
		.div_taps   (div_taps),
		.timer_regs (timer_regs),
		.timer_irq  (timer_irq)
	);

	apu_frame_seq apu_frame_seq_inst (
		.clkin_a    (clkin_a),
		.sys_nreset (rst_out.sys_nreset),
		.apu_on     (apu_on),
		.div_taps   (div_taps),
		.frame_clk  (frame_clk)
	);

endmodule

//--- src/timer_unit.sv
`timescale 1ns/100ps

`include "dmg_timing_consts.svh"

module timer_unit import dmg_timing_pkg::*; (
	input  logic                      clkin_a,
	input  logic                      sys_nreset,
	input  reg_wr_t                   reg_wr,
	input  logic [`DMG_DIV_WIDTH-1:0] div_taps,
	output timer_regs_t               timer_regs,
	output logic                      timer_irq
);

	logic tap_sel;
	logic timer_in;
	logic timer_in_q;
	logic tick;
	logic wr_tima;
	logic wr_tma;
	logic wr_tac;

	always_comb begin
		case (timer_regs.tac[1:0])
			2'd0: tap_sel = div_taps[`DMG_TAP_4096];
			2'd1: tap_sel = div_taps[`DMG_TAP_262144];
			2'd2: tap_sel = div_taps[`DMG_TAP_65536];
			default: tap_sel = div_taps[`DMG_TAP_16384];
		endcase
	end

	// turning the enable off while the tap is high also counts as a falling edge.
	assign timer_in = timer_regs.tac[2] & tap_sel;
	assign tick = timer_in_q & ~timer_in;

	assign wr_tima = reg_wr.stb && (reg_wr.sel == REG_TIMA);
	assign wr_tma = reg_wr.stb && (reg_wr.sel == REG_TMA);
	assign wr_tac = reg_wr.stb && (reg_wr.sel == REG_TAC);

	always_ff @(posedge clkin_a or negedge sys_nreset) begin
		if (!sys_nreset) begin
			timer_regs <= '0;
			timer_in_q <= 1'b0;
			timer_irq <= 1'b0;
		end else begin
			timer_in_q <= timer_in;
			timer_irq <= 1'b0;
			if (wr_tima) begin
				timer_regs.tima <= reg_wr.data; // the cpu write wins over a tick.
			end else if (tick) begin
				if (timer_regs.tima == 8'hff) begin
					timer_regs.tima <= timer_regs.tma;
					timer_irq <= 1'b1;
				end else begin
					timer_regs.tima <= timer_regs.tima + 8'd1;
				end
			end
			if (wr_tma) begin
				timer_regs.tma <= reg_wr.data;
			end
			if (wr_tac) begin
				timer_regs.tac <= reg_wr.data[2:0];
			end
		end
	end

	a_irq_pulse: assert property (@(posedge clkin_a) disable iff (!sys_nreset)
		timer_irq |=> !timer_irq)
		else $error("timer_irq high for two cycles");

endmodule

//--- verif/dmg_timing_tb.sv
`timescale 1ns/100ps

`include "dmg_timing_consts.svh"

module dmg_timing_tb import dmg_timing_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int RELEASE_DELAY = 1025;
	localparam int DIV_ROUNDS = 16;
	localparam int DIV_MAX_GAP = 300;
	localparam int TIMER_TICKS = 20;
	localparam int FRAME_PERIOD = 8192; // one period of divider bit 12.
	localparam int TEST_CYCLES = RESET_CYCLES + RELEASE_DELAY + 200
		+ DIV_ROUNDS * (DIV_MAX_GAP + 12)
		+ TIMER_TICKS * (1024 + 256 + 64 + 16) + 4 * 64
		+ 11 * FRAME_PERIOD + 400;
	localparam longint WATCHDOG_NS = longint'(TEST_CYCLES) * 11 / 10 * 10;

	typedef struct packed {
		logic [15:0] div;
		phase_e      phase;
		rst_state_e  rst_state;
		logic        sys;
		logic        video;
		logic        tin_q;
		timer_regs_t regs;
		logic        irq;
		logic        fbit_q;
		logic        tick_q;
		logic [2:0]  step;
	} model_t;

	typedef struct packed {
		logic [7:0] rdata;
		rst_out_t   rst;
		logic       phi;
		logic       mcycle;
		logic       irq;
		frame_clk_t frame;
	} expect_t;

	logic        clkin_a;
	logic        rst_n;
	bus_req_t    bus_req;
	logic        lcd_on;
	logic        apu_on;
	logic [7:0]  rdata;
	rst_out_t    rst_out;
	logic        phi;
	logic        mcycle;
	logic        timer_irq;
	frame_clk_t  frame_clk;
	model_t      model;
	expect_t     expected;
	logic        model_valid = 1'b0;
	int unsigned cyc = 0;
	int unsigned irq_seen = 0;
	int unsigned env_seen = 0;

	dmg_timing_top dmg_timing_top_inst (
		.clkin_a   (clkin_a),
		.rst_n     (rst_n),
		.bus_req   (bus_req),
		.lcd_on    (lcd_on),
		.apu_on    (apu_on),
		.rdata     (rdata),
		.rst_out   (rst_out),
		.phi       (phi),
		.mcycle    (mcycle),
		.timer_irq (timer_irq),
		.frame_clk (frame_clk)
	);

	always #5 clkin_a = ~clkin_a;

	function automatic int tap_bit(input logic [1:0] sel);
		case (sel)
			2'd0: return 9;
			2'd1: return 3;
			2'd2: return 5;
			default: return 7;
		endcase
	endfunction

	function automatic int tap_period(input int ctrl);
		return 2 << tap_bit(ctrl[1:0]); // one falling edge per full period of the tap.
	endfunction

	// next state of the whole block from the inputs seen at a rising edge.
	function automatic model_t next_model(model_t m, bus_req_t bus, logic lcd, logic apu);
		model_t n;
		logic   wr_stb;
		logic   timer_in;
		logic   tick;
		logic   fall;
		n = m;
		wr_stb = bus.wr && (m.phase == PH_D);
		n.phase = phase_e'(m.phase + 2'd1);
		n.div = (wr_stb && bus.addr == `DMG_ADDR_DIV) ? 16'h0000 : m.div + 16'd1;
		case (m.rst_state)
			RST_HOLD: n.rst_state = RST_WAIT;
			RST_WAIT: n.rst_state = m.div[10] ? RST_RUN : RST_WAIT;
			default: n.rst_state = RST_RUN;
		endcase
		n.sys = (n.rst_state == RST_RUN);
		n.video = m.sys & lcd;
		if (!m.sys) begin
			n.tin_q = 1'b0;
			n.regs = '0;
			n.irq = 1'b0;
			n.fbit_q = 1'b0;
			n.tick_q = 1'b0;
			n.step = 3'd0;
		end else begin
			timer_in = m.regs.tac[2] & m.div[tap_bit(m.regs.tac[1:0])];
			tick = m.tin_q & ~timer_in;
			n.tin_q = timer_in;
			n.irq = 1'b0;
			if (wr_stb && bus.addr == `DMG_ADDR_TIMA) begin
				n.regs.tima = bus.wdata;
			end else if (tick && m.regs.tima == 8'hff) begin
				n.regs.tima = m.regs.tma;
				n.irq = 1'b1;
			end else if (tick) begin
				n.regs.tima = m.regs.tima + 8'd1;
			end
			if (wr_stb && bus.addr == `DMG_ADDR_TMA) begin
				n.regs.tma = bus.wdata;
			end
			if (wr_stb && bus.addr == `DMG_ADDR_TAC) begin
				n.regs.tac = bus.wdata[2:0];
			end
			fall = m.fbit_q & ~m.div[12];
			n.fbit_q = m.div[12];
			n.tick_q = apu & fall;
			if (!apu) begin
				n.step = 3'd0;
			end else if (fall) begin
				n.step = m.step + 3'd1;
			end
		end
		return n;
	endfunction

	function automatic expect_t expected_outputs(model_t m, bus_req_t bus, logic apu);
		expect_t e;
		logic    tick;
		e.rdata = 8'h00;
		if (bus.rd) begin
			case (bus.addr)
				`DMG_ADDR_DIV: e.rdata = m.div[15:8];
				`DMG_ADDR_TIMA: e.rdata = m.regs.tima;
				`DMG_ADDR_TMA: e.rdata = m.regs.tma;
				`DMG_ADDR_TAC: e.rdata = {5'b11111, m.regs.tac};
				default: e.rdata = 8'h00;
			endcase
		end
		e.rst.sys_nreset = m.sys;
		e.rst.video_nreset = m.video;
		e.phi = (m.phase == PH_C) || (m.phase == PH_D);
		e.mcycle = (m.phase == PH_D);
		e.irq = m.irq;
		tick = m.tick_q & apu;
		e.frame.length_clk = tick & ~m.step[0];
		e.frame.sweep_clk = tick & ((m.step == 3'd2) || (m.step == 3'd6));
		e.frame.env_clk = tick & (m.step == 3'd7);
		e.frame.step = apu ? m.step : 3'd0;
		return e;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			stop_with_failure($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_rst(input string name, input rst_out_t got, input rst_out_t want);
		if (got !== want) begin
			stop_with_failure($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_frame(input string name, input frame_clk_t got, input frame_clk_t want);
		if (got !== want) begin
			stop_with_failure($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_irq(input string name, input logic got, input logic want);
		if (got !== want) begin
			stop_with_failure($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			stop_with_failure($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, got, want));
		end
	endtask

	task automatic wait_cycles(input int unsigned n);
		repeat (n) @(posedge clkin_a);
		#1;
	endtask

	// holds the request for one whole machine cycle.
	task automatic bus_access(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic rd);
		@(posedge clkin_a);
		#1;
		bus_req.addr = addr;
		bus_req.wdata = data;
		bus_req.wr = wr;
		bus_req.rd = rd;
		repeat (4) @(posedge clkin_a);
		#1;
		bus_req.wr = 1'b0;
		bus_req.rd = 1'b0;
	endtask

	always @(posedge clkin_a) begin
		cyc = cyc + 1;
		model = rst_n ? next_model(model, bus_req, lcd_on, apu_on) : model_t'('0);
		model_valid = 1'b1;
	end

	always @(negedge clkin_a) begin
		if (model_valid) begin
			expected = expected_outputs(model, bus_req, apu_on);
			check_byte("rdata", rdata, expected.rdata);
			check_rst("rst_out", rst_out, expected.rst);
			check_bit("phi", phi, expected.phi);
			check_bit("mcycle", mcycle, expected.mcycle);
			check_irq("timer_irq", timer_irq, expected.irq);
			check_frame("frame_clk", frame_clk, expected.frame);
			irq_seen += timer_irq;
			env_seen += frame_clk.env_clk;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("watchdog expired before the tests finished");
	end

	initial begin
		int unsigned rel_cyc;
		int unsigned irq_before;
		int          ctrl;
		int          i;
		clkin_a = 1'b0;
		rst_n = 1'b0;
		bus_req = '0;
		lcd_on = 1'b1;
		apu_on = 1'b1;
		void'($urandom(97));
		repeat (RESET_CYCLES) @(posedge clkin_a);
		#1;
		rst_n = 1'b1;
		rel_cyc = cyc;
		bus_access(`DMG_ADDR_TIMA, 8'($urandom), 1'b1, 1'b0); // system reset still held here.
		bus_access(`DMG_ADDR_TMA, 8'($urandom), 1'b1, 1'b0);
		bus_access(`DMG_ADDR_TAC, 8'($urandom), 1'b1, 1'b0);
		bus_access(`DMG_ADDR_TIMA, 8'h00, 1'b0, 1'b1);
		bus_access(`DMG_ADDR_TMA, 8'h00, 1'b0, 1'b1);
		bus_access(`DMG_ADDR_TAC, 8'h00, 1'b0, 1'b1);
		while (!rst_out.sys_nreset) begin
			if (cyc - rel_cyc > RELEASE_DELAY + 64) begin
				stop_with_failure("sys_nreset never rose after reset release");
			end
			wait_cycles(1);
		end
		if (cyc - rel_cyc != RELEASE_DELAY) begin
			stop_with_failure($sformatf("ERROR: release delay is 0x%h cycles, expected 0x%h",
				cyc - rel_cyc, RELEASE_DELAY));
		end
		wait_cycles(20);
		lcd_on = 1'b0;
		wait_cycles(30);
		lcd_on = 1'b1;
		wait_cycles(1);
		lcd_on = 1'b0;
		wait_cycles(1);
		lcd_on = 1'b1;
		wait_cycles(20);
		for (i = 0; i < DIV_ROUNDS; i++) begin
			wait_cycles($urandom_range(1, DIV_MAX_GAP));
			bus_access(`DMG_ADDR_DIV, 8'($urandom), 1'b0, 1'b1);
			if (i % 4 == 3) begin
				bus_access(`DMG_ADDR_DIV, 8'($urandom), 1'b1, 1'b0);
				bus_access(`DMG_ADDR_DIV, 8'h00, 1'b0, 1'b1);
			end
		end
		for (ctrl = 0; ctrl < 4; ctrl++) begin
			bus_access(`DMG_ADDR_TMA, {5'b11111, 3'($urandom)}, 1'b1, 1'b0);
			bus_access(`DMG_ADDR_TAC, {5'($urandom), 1'b1, 2'(ctrl)}, 1'b1, 1'b0);
			bus_access(`DMG_ADDR_TIMA, 8'hfc, 1'b1, 1'b0);
			irq_before = irq_seen;
			wait_cycles(TIMER_TICKS * tap_period(ctrl));
			bus_access(`DMG_ADDR_TIMA, 8'h00, 1'b0, 1'b1);
			if (irq_seen == irq_before) begin
				stop_with_failure($sformatf("no timer interrupt for control value %0d", ctrl));
			end
			repeat (4) bus_access(`DMG_ADDR_TIMA, 8'($urandom), 1'b1, 1'b0); // writes near ticks.
			bus_access(`DMG_ADDR_TAC, 8'h00, 1'b1, 1'b0);
		end
		wait_cycles(9 * FRAME_PERIOD + 100);
		if (env_seen == 0) begin
			stop_with_failure("frame sequencer never reached step 7");
		end
		apu_on = 1'b0;
		wait_cycles(FRAME_PERIOD + 100);
		apu_on = 1'b1;
		wait_cycles(FRAME_PERIOD + 100);
		$display("NO ERRORS");
		$finish;
	end

endmodule
